// File: common/gmii_tx_pkg.sv
package gmii_tx_pkg;

   // Sizing defaults, passed down from the top level
   localparam int NUM_CHANNELS_DEF = 4;
   localparam int BUF_DEPTH_DEF    = 64;   // Bytes per channel, power of two

   // Channel tag width on the shared input port
   localparam int CHAN_W_MAX       = 2;

   // Ethernet framing
   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0] SFD_BYTE      = 8'hD5;
   localparam int         PREAMBLE_LEN  = 7;
   localparam int         IFG_CYCLES    = 12;   // Minimum idle cycles between frames

   // FCS, reflected CRC-32 as used on the wire
   localparam logic [31:0] CRC_POLY = 32'hEDB88320;
   localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

endpackage

// File: design/frame_dispatch.sv
module frame_dispatch #(
   parameter int NUM_CHANNELS = gmii_tx_pkg::NUM_CHANNELS_DEF
) (
   input  logic                               GMII_GTX_CLK_int,
   input  logic                               rst_i,
   input  logic                               in_valid_i,
   input  logic [7:0]                         in_data_i,
   input  logic                               in_last_i,
   input  logic [gmii_tx_pkg::CHAN_W_MAX-1:0] in_chan_i,
   input  logic [NUM_CHANNELS-1:0]            full_i,
   output logic [NUM_CHANNELS-1:0]            wr_en_o,
   output logic [7:0]                         wr_data_o,
   output logic                               wr_last_o,
   output logic [NUM_CHANNELS-1:0]            abort_o,
   output logic                               drop_o
);
   import gmii_tx_pkg::*;

   logic                  in_frame_q;   // Between first and last byte
   logic                  discard_q;    // Rest of an aborted frame
   logic [CHAN_W_MAX-1:0] chan_q;
   logic [CHAN_W_MAX-1:0] cur_chan;
   logic                  chan_ok;
   logic                  blocked;

   // Tag is only taken from the first byte of a frame
   assign cur_chan = in_frame_q ? chan_q : in_chan_i;
   assign chan_ok  = int'(cur_chan) < NUM_CHANNELS;
   assign blocked  = !chan_ok || full_i[cur_chan];   // Full already counts the write in flight

   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (rst_i)
      begin
         in_frame_q <= 1'b0;
         discard_q  <= 1'b0;
         chan_q     <= '0;
         wr_en_o    <= '0;
         abort_o    <= '0;
         drop_o     <= 1'b0;
      end
      else
      begin
         wr_en_o <= '0;
         abort_o <= '0;
         drop_o  <= 1'b0;
         if (in_valid_i)
         begin
            chan_q     <= cur_chan;
            in_frame_q <= !in_last_i;
            if (discard_q)
            begin
               if (in_last_i)
                  discard_q <= 1'b0;
            end
            else if (blocked)
            begin
               // Rewind the partial frame, report once, skip to its end
               if (chan_ok)
                  abort_o[cur_chan] <= 1'b1;
               drop_o    <= 1'b1;
               discard_q <= !in_last_i;
            end
            else
               wr_en_o[cur_chan] <= 1'b1;
         end
      end
   end

   // Byte and last flag toward all buffers
   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (in_valid_i)
      begin
         wr_data_o <= in_data_i;
         wr_last_o <= in_last_i;
      end
   end

endmodule

// File: design/gmii_tx_top.sv
module gmii_tx_top #(
   parameter int NUM_CHANNELS = gmii_tx_pkg::NUM_CHANNELS_DEF,
   parameter int BUF_DEPTH    = gmii_tx_pkg::BUF_DEPTH_DEF
) (
   input  logic                               GMII_GTX_CLK_int,
   input  logic                               rst_i,
   input  logic                               in_valid_i,
   input  logic [7:0]                         in_data_i,
   input  logic                               in_last_i,
   input  logic [gmii_tx_pkg::CHAN_W_MAX-1:0] in_chan_i,
   output logic [7:0]                         gmii_txd_o,
   output logic                               gmii_tx_en_o,
   output logic                               drop_o
);
   import gmii_tx_pkg::*;

   // Dispatcher to buffers
   logic [NUM_CHANNELS-1:0] wr_en;
   logic [7:0]              wr_data;
   logic                    wr_last;
   logic [NUM_CHANNELS-1:0] abort;
   logic [NUM_CHANNELS-1:0] full;

   // Buffers to framer
   logic [NUM_CHANNELS-1:0] frame_ready;
   logic [7:0]              rd_data [NUM_CHANNELS];
   logic [NUM_CHANNELS-1:0] rd_last;
   logic [NUM_CHANNELS-1:0] rd_en;

   // Tag port must reach every channel
   if (NUM_CHANNELS > (1 << CHAN_W_MAX)) begin : g_chan_check
      $error("NUM_CHANNELS does not fit the channel tag width");
   end

   if (BUF_DEPTH != (1 << $clog2(BUF_DEPTH))) begin : g_depth_check
      $error("BUF_DEPTH must be a power of two");
   end

   frame_dispatch #(
      .NUM_CHANNELS (NUM_CHANNELS)
   ) u_dispatch (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .rst_i            (rst_i),
      .in_valid_i       (in_valid_i),
      .in_data_i        (in_data_i),
      .in_last_i        (in_last_i),
      .in_chan_i        (in_chan_i),
      .full_i           (full),
      .wr_en_o          (wr_en),
      .wr_data_o        (wr_data),
      .wr_last_o        (wr_last),
      .abort_o          (abort),
      .drop_o           (drop_o)
   );

   for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_buf
      frame_buffer #(
         .BUF_DEPTH (BUF_DEPTH)
      ) u_buf (
         .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
         .rst_i            (rst_i),
         .wr_en_i          (wr_en[ch]),
         .wr_data_i        (wr_data),
         .wr_last_i        (wr_last),
         .abort_i          (abort[ch]),
         .rd_en_i          (rd_en[ch]),
         .full_o           (full[ch]),
         .frame_ready_o    (frame_ready[ch]),
         .rd_data_o        (rd_data[ch]),
         .rd_last_o        (rd_last[ch])
      );
   end

   gmii_tx_framer #(
      .NUM_CHANNELS (NUM_CHANNELS)
   ) u_framer (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .rst_i            (rst_i),
      .frame_ready_i    (frame_ready),
      .rd_data_i        (rd_data),
      .rd_last_i        (rd_last),
      .rd_en_o          (rd_en),
      .gmii_txd_o       (gmii_txd_o),
      .gmii_tx_en_o     (gmii_tx_en_o)
   );

endmodule

// File: files.f
common/gmii_tx_pkg.sv
design/frame_dispatch.sv
frame_buffer/frame_buffer.sv
gmii_framer/gmii_tx_framer.sv
design/gmii_tx_top.sv
testbench/gmii_tx_properties.sv
testbench/tb_gmii_tx.sv

// File: frame_buffer/frame_buffer.sv
module frame_buffer #(
   parameter int BUF_DEPTH = gmii_tx_pkg::BUF_DEPTH_DEF
) (
   input  logic       GMII_GTX_CLK_int,
   input  logic       rst_i,
   input  logic       wr_en_i,
   input  logic [7:0] wr_data_i,
   input  logic       wr_last_i,
   input  logic       abort_i,
   input  logic       rd_en_i,
   output logic       full_o,
   output logic       frame_ready_o,
   output logic [7:0] rd_data_o,
   output logic       rd_last_o
);

   localparam int AW = $clog2(BUF_DEPTH);

   // Each entry holds the last flag above the byte
   logic [8:0]    mem [BUF_DEPTH];

   // Pointers carry one extra wrap bit
   logic [AW:0]   wr_ptr_q;      // Working write position
   logic [AW:0]   wr_commit_q;   // End of the last complete frame
   logic [AW:0]   rd_ptr_q;
   logic [AW:0]   frames_q;      // Committed frames not yet read out

   logic [AW:0]   wr_base;
   logic [AW:0]   used;
   logic [AW+1:0] fill;
   logic          commit;
   logic          release_frame;

   assign commit        = wr_en_i && wr_last_i;
   assign release_frame = rd_en_i && rd_last_o;

   // An abort in progress frees the partial frame this cycle
   assign wr_base = abort_i ? wr_commit_q : wr_ptr_q;
   assign used    = wr_base - rd_ptr_q;
   assign fill    = {1'b0, used} + (AW + 2)'(wr_en_i);
   assign full_o  = fill >= (AW + 2)'(BUF_DEPTH);

   assign frame_ready_o = frames_q != '0;

   // Current read position, shown without a clock
   assign rd_data_o = mem[rd_ptr_q[AW-1:0]][7:0];
   assign rd_last_o = mem[rd_ptr_q[AW-1:0]][8];

   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (wr_en_i)
         mem[wr_ptr_q[AW-1:0]] <= {wr_last_i, wr_data_i};
   end

   // Write side, commit on last and rewind on abort
   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (rst_i)
      begin
         wr_ptr_q    <= '0;
         wr_commit_q <= '0;
      end
      else if (abort_i)
         wr_ptr_q <= wr_commit_q;
      else if (wr_en_i)
      begin
         wr_ptr_q <= wr_ptr_q + 1'b1;
         if (wr_last_i)
            wr_commit_q <= wr_ptr_q + 1'b1;
      end
   end

   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (rst_i)
         rd_ptr_q <= '0;
      else if (rd_en_i)
         rd_ptr_q <= rd_ptr_q + 1'b1;
   end

   // Frame count, up on commit and down when a last byte leaves
   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (rst_i)
         frames_q <= '0;
      else
      begin
         case ({commit, release_frame})
            2'b10:   frames_q <= frames_q + 1'b1;
            2'b01:   frames_q <= frames_q - 1'b1;
            default: frames_q <= frames_q;
         endcase
      end
   end

endmodule

// File: gmii_framer/gmii_tx_framer.sv
module gmii_tx_framer #(
   parameter int NUM_CHANNELS = gmii_tx_pkg::NUM_CHANNELS_DEF
) (
   input  logic                    GMII_GTX_CLK_int,
   input  logic                    rst_i,
   input  logic [NUM_CHANNELS-1:0] frame_ready_i,
   input  logic [7:0]              rd_data_i [NUM_CHANNELS],
   input  logic [NUM_CHANNELS-1:0] rd_last_i,
   output logic [NUM_CHANNELS-1:0] rd_en_o,
   output logic [7:0]              gmii_txd_o,
   output logic                    gmii_tx_en_o
);
   import gmii_tx_pkg::*;

   localparam int SEL_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

   typedef enum logic [2:0] {
      S_IDLE,
      S_PRE,
      S_SFD,
      S_DATA,
      S_FCS,
      S_GAP
   } state_t;

   state_t           state_q;
   logic [SEL_W-1:0] sel_q;        // Channel being sent, or last one served
   logic [SEL_W-1:0] grant_idx;
   logic             grant_found;
   logic [7:0]       cnt_q;        // Shared by preamble, FCS and gap
   logic [31:0]      crc_q;
   logic [31:0]      fcs;
   logic [7:0]       cur_data;
   logic             cur_last;
   logic [7:0]       txd_d;        // Unregistered GMII data
   logic             tx_en_d;

   // One byte of the reflected CRC-32, LSB first
   function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      c = crc ^ {24'h0, data};
      for (int b = 0; b < 8; b++)
         c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
      return c;
   endfunction

   assign cur_data = rd_data_i[sel_q];
   assign cur_last = rd_last_i[sel_q];
   assign fcs      = ~crc_q;

   // Round-robin search, starting after the last channel served
   always_comb
   begin
      int unsigned cand;
      grant_found = 1'b0;
      grant_idx   = sel_q;
      for (int i = 1; i <= NUM_CHANNELS; i++)
      begin
         cand = (int'(sel_q) + i) % NUM_CHANNELS;
         if (!grant_found && frame_ready_i[cand])
         begin
            grant_found = 1'b1;
            grant_idx   = SEL_W'(cand);
         end
      end
   end

   // Line contents per phase
   always_comb
   begin
      txd_d   = 8'h00;
      tx_en_d = 1'b0;
      rd_en_o = '0;
      case (state_q)
         S_PRE:
         begin
            txd_d   = PREAMBLE_BYTE;
            tx_en_d = 1'b1;
         end
         S_SFD:
         begin
            txd_d   = SFD_BYTE;
            tx_en_d = 1'b1;
         end
         S_DATA:
         begin
            txd_d          = cur_data;
            tx_en_d        = 1'b1;
            rd_en_o[sel_q] = 1'b1;   // Next byte shows up next cycle
         end
         S_FCS:
         begin
            txd_d   = fcs[8 * cnt_q[1:0] +: 8];   // Low byte first
            tx_en_d = 1'b1;
         end
         default: ;
      endcase
   end

   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (rst_i)
      begin
         state_q <= S_IDLE;
         sel_q   <= SEL_W'(NUM_CHANNELS - 1);   // Channel 0 wins first
         cnt_q   <= '0;
      end
      else
      begin
         case (state_q)
            S_IDLE:
               if (grant_found)
               begin
                  sel_q   <= grant_idx;
                  cnt_q   <= '0;
                  state_q <= S_PRE;
               end
            S_PRE:
               if (cnt_q == PREAMBLE_LEN - 1)
                  state_q <= S_SFD;
               else
                  cnt_q <= cnt_q + 1'b1;
            S_SFD:
               state_q <= S_DATA;
            S_DATA:
               if (cur_last)
               begin
                  cnt_q   <= '0;
                  state_q <= S_FCS;
               end
            S_FCS:
               if (cnt_q == 3)
               begin
                  cnt_q   <= '0;
                  state_q <= S_GAP;
               end
               else
                  cnt_q <= cnt_q + 1'b1;
            S_GAP:
               // The idle cycle after this adds one more low cycle
               if (cnt_q == IFG_CYCLES - 1)
                  state_q <= S_IDLE;
               else
                  cnt_q <= cnt_q + 1'b1;
            default:
               state_q <= S_IDLE;
         endcase
      end
   end

   // CRC over payload only
   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (state_q == S_IDLE)
         crc_q <= CRC_INIT;
      else if (state_q == S_DATA)
         crc_q <= crc32_byte(crc_q, cur_data);
   end

   // Registered GMII output stage
   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (rst_i)
         gmii_tx_en_o <= 1'b0;
      else
         gmii_tx_en_o <= tx_en_d;
   end

   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      gmii_txd_o <= txd_d;
   end

endmodule

// File: testbench/gmii_tx_properties.sv
module gmii_tx_properties #(
   parameter int NUM_CHANNELS = gmii_tx_pkg::NUM_CHANNELS_DEF
) (
   input  logic                    GMII_GTX_CLK_int,
   input  logic                    rst_i,
   input  logic [NUM_CHANNELS-1:0] frame_ready_i,
   input  logic [NUM_CHANNELS-1:0] rd_en_i,
   input  logic                    tx_en_i
);
   import gmii_tx_pkg::*;

   logic [7:0] low_cnt_q;   // Low cycles since tx_en fell, saturating

   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (rst_i)
         low_cnt_q <= 8'(IFG_CYCLES);   // First frame needs no gap
      else if (tx_en_i)
         low_cnt_q <= '0;
      else if (low_cnt_q != 8'hFF)
         low_cnt_q <= low_cnt_q + 1'b1;
   end

   // Reads only from a buffer holding a committed frame
   a_rd_needs_ready: assert property (@(posedge GMII_GTX_CLK_int) disable iff (rst_i)
      (rd_en_i & ~frame_ready_i) == '0)
      else $error("rd_en raised for a channel without a committed frame");

   // A read hits one channel and its byte goes out on the next cycle
   a_rd_onehot: assert property (@(posedge GMII_GTX_CLK_int) disable iff (rst_i)
      rd_en_i != '0 |-> $onehot(rd_en_i) ##1 tx_en_i)
      else $error("rd_en active on more than one channel or without tx_en following");

   a_ifg: assert property (@(posedge GMII_GTX_CLK_int) disable iff (rst_i)
      $rose(tx_en_i) |-> low_cnt_q >= IFG_CYCLES)
      else $error("inter-frame gap shorter than %0d cycles", IFG_CYCLES);

endmodule

bind gmii_tx_framer gmii_tx_properties #(
   .NUM_CHANNELS (NUM_CHANNELS)
) u_props (
   .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
   .rst_i            (rst_i),
   .frame_ready_i    (frame_ready_i),
   .rd_en_i          (rd_en_o),
   .tx_en_i          (gmii_tx_en_o)
);

// File: testbench/tb_gmii_tx.sv
module tb_gmii_tx;
   import gmii_tx_pkg::*;

   localparam int NUM_CH      = NUM_CHANNELS_DEF;
   localparam int DEPTH       = BUF_DEPTH_DEF;
   localparam int NUM_FRAMES  = 60;
   localparam int MAX_LEN     = DEPTH + 24;
   localparam int DRAIN_LIMIT = NUM_CH * DEPTH * 30 + 1000;
   localparam logic [31:0] SEED = 32'h3d6fd66f;

   // Line constants as the model sees them
   localparam logic [7:0]  EXP_PRE  = PREAMBLE_BYTE;
   localparam logic [7:0]  EXP_SFD  = SFD_BYTE;
   localparam logic [31:0] EXP_POLY = CRC_POLY;
   localparam logic [31:0] EXP_INIT = CRC_INIT;

   logic                  GMII_GTX_CLK_int = 1'b0;
   logic                  rst_i;
   logic                  in_valid_i;
   logic [7:0]            in_data_i;
   logic                  in_last_i;
   logic [CHAN_W_MAX-1:0] in_chan_i;
   logic [7:0]            gmii_txd_o;
   logic                  gmii_tx_en_o;
   logic                  drop_o;

   // Stimulus made up front so the timeout is known before reset
   int         frame_len  [NUM_FRAMES];
   int         frame_chan [NUM_FRAMES];
   bit         frame_big  [NUM_FRAMES];   // Longer than a buffer
   logic [7:0] frame_data [NUM_FRAMES][MAX_LEN];

   int         pending[$];                 // Frame indices still expected on the line
   int         outstanding [NUM_CH];       // Bytes per channel not yet seen
   logic [7:0] rx_bytes[$];
   int         errors      = 0;
   int         frames_sent = 0;
   int         frames_rx   = 0;
   int         drops_exp   = 0;
   int         drops_seen  = 0;
   int         total_bytes = 0;
   int         cycles      = 0;
   int         limit       = 0;
   int         gap_cnt     = 0;
   bit         seen_frame  = 1'b0;
   logic       tx_en_q     = 1'b0;

   gmii_tx_top #(
      .NUM_CHANNELS (NUM_CH),
      .BUF_DEPTH    (DEPTH)
   ) DUT (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .rst_i            (rst_i),
      .in_valid_i       (in_valid_i),
      .in_data_i        (in_data_i),
      .in_last_i        (in_last_i),
      .in_chan_i        (in_chan_i),
      .gmii_txd_o       (gmii_txd_o),
      .gmii_tx_en_o     (gmii_tx_en_o),
      .drop_o           (drop_o)
   );

   initial
   begin
      forever #5 GMII_GTX_CLK_int = ~GMII_GTX_CLK_int;
   end

   // Ethernet FCS over one stored payload, already inverted
   function automatic logic [31:0] model_fcs(input int idx);
      logic [31:0] crc;
      crc = EXP_INIT;
      for (int n = 0; n < frame_len[idx]; n++)
      begin
         crc = crc ^ {24'h0, frame_data[idx][n]};
         for (int b = 0; b < 8; b++)
            crc = (crc >> 1) ^ (EXP_POLY & {32{crc[0]}});
      end
      return ~crc;
   endfunction

   task automatic send_frame(input int f);
      int ch;
      ch = frame_chan[f];
      if (frame_big[f])
         drops_exp++;
      else
      begin
         // Hold back until the channel has room for the whole frame
         while (outstanding[ch] + frame_len[f] > DEPTH)
            @(posedge GMII_GTX_CLK_int);
         outstanding[ch] += frame_len[f];
         pending.push_back(f);
      end
      frames_sent++;
      for (int n = 0; n < frame_len[f]; n++)
      begin
         @(posedge GMII_GTX_CLK_int);
         in_valid_i <= 1'b1;
         in_data_i  <= frame_data[f][n];
         in_last_i  <= (n == frame_len[f] - 1);
         in_chan_i  <= CHAN_W_MAX'(ch);
      end
      @(posedge GMII_GTX_CLK_int);
      in_valid_i <= 1'b0;
      in_last_i  <= 1'b0;
   endtask

   task automatic check_frame();
      int          n_pay;
      int          ch;
      int          pos;
      int          idx;
      int          bad;
      logic [31:0] got_fcs;
      logic [31:0] exp_fcs;
      if (rx_bytes.size() < 13)
      begin
         $display("%0t: frame of %0d bytes is too short for preamble, data and FCS",
                  $time, rx_bytes.size());
         errors++;
         return;
      end
      for (int n = 0; n < 8; n++)
      begin
         if (rx_bytes[n] !== ((n == 7) ? EXP_SFD : EXP_PRE))
         begin
            $display("[FAIL] %0t gmii_txd_o byte %0d expected %02h got %02h", $time, n,
                     (n == 7) ? EXP_SFD : EXP_PRE, rx_bytes[n]);
            errors++;
         end
      end
      n_pay = rx_bytes.size() - 12;
      ch    = rx_bytes[8];
      pos   = -1;
      // Oldest frame still expected on that channel
      for (int p = 0; p < pending.size(); p++)
      begin
         if (pos < 0 && frame_chan[pending[p]] == ch)
            pos = p;
      end
      if (pos < 0)
      begin
         $display("%0t: a frame tagged for channel %0d appeared but none was expected",
                  $time, ch);
         errors++;
         return;
      end
      idx = pending[pos];
      pending.delete(pos);
      frames_rx++;
      outstanding[ch] -= frame_len[idx];
      if (n_pay != frame_len[idx])
      begin
         $display("%0t: frame %0d on channel %0d carried %0d payload bytes instead of %0d",
                  $time, idx, ch, n_pay, frame_len[idx]);
         errors++;
         return;
      end
      bad = 0;
      for (int n = 0; n < n_pay; n++)
      begin
         if (rx_bytes[8 + n] !== frame_data[idx][n])
         begin
            if (bad == 0)
               $display("[FAIL] %0t gmii_txd_o payload byte %0d expected %02h got %02h",
                        $time, n, frame_data[idx][n], rx_bytes[8 + n]);
            bad++;
         end
      end
      if (bad != 0)
         errors++;
      got_fcs = {rx_bytes[n_pay + 11], rx_bytes[n_pay + 10], rx_bytes[n_pay + 9],
                 rx_bytes[n_pay + 8]};
      exp_fcs = model_fcs(idx);
      if (got_fcs !== exp_fcs)
      begin
         $display("[FAIL] %0t gmii_txd_o FCS expected %08h got %08h", $time, exp_fcs, got_fcs);
         errors++;
      end
   endtask

   // Line monitor, away from the clock edge
   always @(negedge GMII_GTX_CLK_int)
   begin
      if (rst_i)
      begin
         if (gmii_tx_en_o !== 1'b0)
         begin
            $display("%0t: gmii_tx_en_o is not low during reset", $time);
            errors++;
         end
         tx_en_q = 1'b0;
      end
      else
      begin
         if (drop_o)
            drops_seen++;
         if (gmii_tx_en_o)
         begin
            if (!tx_en_q && frames_sent == 0)
            begin
               $display("%0t: gmii_tx_en_o rose before any frame was sent", $time);
               errors++;
            end
            if (!tx_en_q && seen_frame && gap_cnt < IFG_CYCLES)
            begin
               $display("[FAIL] %0t gmii_tx_en_o low cycles expected >= %0d got %0d",
                        $time, IFG_CYCLES, gap_cnt);
               errors++;
            end
            rx_bytes.push_back(gmii_txd_o);
         end
         else
         begin
            if (tx_en_q)
            begin
               check_frame();
               rx_bytes.delete();
               seen_frame = 1'b1;
               gap_cnt    = 0;
            end
            gap_cnt++;
         end
         tx_en_q = gmii_tx_en_o;
      end
   end

   always @(posedge GMII_GTX_CLK_int)
   begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit)
      begin
         $display("Timeout after %0d cycles with %0d frames still expected",
                  cycles, pending.size());
         $display("test failed");
         $finish;
      end
   end

   initial
   begin
      int seed_val;
      int waited;
      seed_val   = $urandom(SEED);
      rst_i      = 1'b1;
      in_valid_i = 1'b0;
      in_data_i  = 8'h00;
      in_last_i  = 1'b0;
      in_chan_i  = '0;
      for (int c = 0; c < NUM_CH; c++)
         outstanding[c] = 0;
      for (int f = 0; f < NUM_FRAMES; f++)
      begin
         frame_big[f]     = (f % 15) == 7;
         frame_chan[f]    = $urandom_range(NUM_CH - 1, 0);
         frame_len[f]     = frame_big[f] ? DEPTH + 1 + $urandom_range(20, 0)
                                         : $urandom_range(DEPTH, 1);
         frame_data[f][0] = 8'(frame_chan[f]);   // First byte names the channel
         for (int n = 1; n < frame_len[f]; n++)
            frame_data[f][n] = 8'($urandom);
         total_bytes += frame_len[f];
      end
      limit = 40 * total_bytes + 2000;

      repeat (16) @(posedge GMII_GTX_CLK_int);
      rst_i <= 1'b0;
      repeat (4) @(posedge GMII_GTX_CLK_int);

      for (int f = 0; f < NUM_FRAMES; f++)
      begin
         send_frame(f);
         repeat ($urandom_range(6, 0)) @(posedge GMII_GTX_CLK_int);
      end

      waited = 0;
      while (pending.size() != 0 && waited < DRAIN_LIMIT)
      begin
         @(posedge GMII_GTX_CLK_int);
         waited++;
      end
      repeat (IFG_CYCLES + 40) @(posedge GMII_GTX_CLK_int);

      if (pending.size() != 0)
      begin
         $display("%0d frames were sent but never appeared on the line", pending.size());
         errors++;
      end
      if (drops_seen != drops_exp)
      begin
         $display("drop_o pulsed %0d times for %0d oversized frames", drops_seen, drops_exp);
         errors++;
      end
      $display("Errors %0d, frames sent %0d, received %0d, drops expected %0d, seen %0d",
               errors, frames_sent, frames_rx, drops_exp, drops_seen);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule
